// File: dv/pad_input_assert.sv
// Port protocol assertions
// Bound to the controller port top level

`timescale 1ns/1ns

module pad_input_assert
	import pce_pad_pkg::*;
(
	input logic    clk_sys,
	input logic    reset,
	input logic    pad_clr,
	input nibble_t pad_nibble
);

	// Reset clears the output register
	reset_clears_nibble: assert property (
		@(posedge clk_sys) reset |=> pad_nibble == 4'h0
	) else $error("pad_nibble not zero one cycle after reset");

	// Console reads zero while clear is held
	clear_forces_zero: assert property (
		@(posedge clk_sys) disable iff (reset) pad_clr |=> pad_nibble == 4'h0
	) else $error("pad_nibble not zero after pad_clr was high");

endmodule

bind pad_input_top pad_input_assert i_assert (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.pad_clr    (pad_clr),
	.pad_nibble (pad_nibble)
);

// File: dv/tb_pad_input.sv
// Testbench for the controller port
// Runs a table of clear, select and mouse operations and compares the
// console nibble and the multitap port against a reference model

`timescale 1ns/1ns

module tb_pad_input
	import pce_pad_pkg::*;
();

	localparam int MAX_ROWS       = 128;
	localparam int ROW_CYCLES     = 6;
	localparam int TIMEOUT_CYCLES = 63;

	localparam logic [2:0] OP_CLEAR  = 3'd0;
	localparam logic [2:0] OP_CLR    = 3'd1;
	localparam logic [2:0] OP_SEL    = 3'd2;
	localparam logic [2:0] OP_PULSE  = 3'd3;
	localparam logic [2:0] OP_STROBE = 3'd4;
	localparam logic [2:0] OP_IDLE   = 3'd5;

	typedef struct packed {
		host_joy_t [4:0] joy;
		mouse_delta_t    mx;
		mouse_delta_t    my;
		logic [1:0]      mbtn;
		logic            swap;
		logic            turbo;
		logic            six;
		logic            men;
		logic [2:0]      op;
		logic [7:0]      arg;
		nibble_t         exp_nib;
		port_idx_t       exp_port;
	} row_t;

	logic         clk_sys;
	logic         reset;
	host_joy_t    joy_a;
	host_joy_t    joy_b;
	host_joy_t    joy_2;
	host_joy_t    joy_3;
	host_joy_t    joy_4;
	logic         swap_pads;
	logic         turbo_tap;
	logic         six_button;
	logic         mouse_en;
	mouse_delta_t mouse_x;
	mouse_delta_t mouse_y;
	logic         mouse_left;
	logic         mouse_right;
	logic         mouse_strobe;
	logic         pad_sel;
	logic         pad_clr;
	nibble_t      pad_nibble;

	row_t        rows [MAX_ROWS];
	row_t        cur;
	int          n_rows;
	logic [31:0] rng = 32'h4a17_df21;
	logic        table_ready = 1'b0;
	int          nib_errors = 0;
	int          port_errors = 0;

	pad_input_top #(
		.MOUSE_TIMEOUT_BITS (6)
	) i_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.swap_pads    (swap_pads),
		.turbo_tap    (turbo_tap),
		.six_button   (six_button),
		.mouse_en     (mouse_en),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_left   (mouse_left),
		.mouse_right  (mouse_right),
		.mouse_strobe (mouse_strobe),
		.pad_sel      (pad_sel),
		.pad_clr      (pad_clr),
		.pad_nibble   (pad_nibble)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================
	// Random words and table building
	// ========================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_words();
		rng = xorshift32(rng);
		cur.joy[0] = rng[11:0];
		cur.joy[1] = rng[23:12];
		rng = xorshift32(rng);
		cur.joy[2] = rng[11:0];
		cur.joy[3] = rng[23:12];
		rng = xorshift32(rng);
		cur.joy[4] = rng[11:0];
		cur.mx = rng[19:12];
		cur.my = rng[27:20];
		cur.mbtn = rng[29:28];
	endtask

	task automatic add_row(input logic [2:0] op, input logic [7:0] arg);
		row_t r;
		r = cur;
		r.op = op;
		r.arg = arg;
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic build_table();
		cur = '0;
		n_rows = 0;
		// Standard pad, swap on odd passes
		for (int k = 0; k < 4; k++) begin
			draw_words();
			cur.swap = k[0];
			add_row(OP_CLEAR, 8'd0);
			add_row(OP_SEL, 8'd1);
			add_row(OP_SEL, 8'd0);
		end
		add_row(OP_CLR, 8'd1);
		add_row(OP_CLR, 8'd0);
		// Multitap, ports 1 to 7 and the wrap
		cur.swap = 1'b0;
		cur.turbo = 1'b1;
		draw_words();
		add_row(OP_CLEAR, 8'd0);
		for (int p = 0; p < 8; p++) begin
			add_row(OP_SEL, 8'd1);
			add_row(OP_SEL, 8'd0);
		end
		add_row(OP_PULSE, 8'd0);
		add_row(OP_PULSE, 8'd0);
		add_row(OP_CLR, 8'd1);
		add_row(OP_CLR, 8'd0);
		cur.turbo = 1'b0;
		add_row(OP_PULSE, 8'd0);
		add_row(OP_SEL, 8'd1);
		// Six-button pad, then back to two phases
		cur.six = 1'b1;
		for (int k = 0; k < 6; k++) begin
			if (k == 4) begin
				cur.six = 1'b0;
			end
			draw_words();
			add_row(OP_CLEAR, 8'd0);
			add_row(OP_SEL, 8'd1);
			add_row(OP_SEL, 8'd0);
		end
		// Mouse bursts, new deltas strobed mid-burst
		cur.men = 1'b1;
		add_row(OP_IDLE, 8'd100);
		draw_words();
		add_row(OP_STROBE, 8'd0);
		for (int b = 0; b < 3; b++) begin
			for (int c = 0; c < 4; c++) begin
				add_row(OP_CLEAR, 8'd0);
				add_row(OP_SEL, 8'd1);
				add_row(OP_SEL, 8'd0);
				if (c == 1) begin
					draw_words();
					add_row(OP_STROBE, 8'd0);
				end
			end
		end
		// Resync after a long idle gap
		add_row(OP_CLEAR, 8'd0);
		add_row(OP_CLEAR, 8'd0);
		draw_words();
		add_row(OP_STROBE, 8'd0);
		add_row(OP_IDLE, 8'd100);
		add_row(OP_CLEAR, 8'd0);
		add_row(OP_SEL, 8'd1);
		add_row(OP_CLEAR, 8'd0);
		add_row(OP_SEL, 8'd1);
	endtask

	// ========================================
	// Reference model
	// ========================================

	// Console layout: III-VI, left down right up, I II select run
	function automatic pad_word_t word_ref(input host_joy_t j);
		pad_word_t w;
		w = 16'h0000;
		w[11:8] = ~j[11:8];
		w[7] = ~j[1];
		w[6] = ~j[2];
		w[5] = ~j[0];
		w[4] = ~j[3];
		w[3:0] = ~j[7:4];
		return w;
	endfunction

	function automatic nibble_t nibble_ref(input row_t r, input port_idx_t port,
			input logic phase, input logic sel, input logic [1:0] cnt,
			input mouse_delta_t rep_x, input mouse_delta_t rep_y);
		host_joy_t pad0;
		host_joy_t pad;
		nibble_t   motion;
		pad_word_t w;
		int        nib_idx;
		pad0 = r.swap ? r.joy[1] : r.joy[0];
		case (port)
			3'd0:    pad = pad0;
			3'd1:    pad = r.swap ? r.joy[0] : r.joy[1];
			3'd2:    pad = r.joy[2];
			3'd3:    pad = r.joy[3];
			default: pad = r.joy[4];
		endcase
		case (cnt)
			2'd0:    motion = rep_x[7:4];
			2'd1:    motion = rep_x[3:0];
			2'd2:    motion = rep_y[7:4];
			default: motion = rep_y[3:0];
		endcase
		w = word_ref(pad);
		if (port > 3'd4) begin
			w = EMPTY_PORT_WORD;
		end else if (port == 3'd0 && r.men) begin
			w = {2{motion, ~pad0[7], ~pad0[6], ~r.mbtn[1], ~r.mbtn[0]}};
		end
		nib_idx = 2 * int'(phase) + int'(sel);
		return w[nib_idx * 4 +: 4];
	endfunction

	task automatic compute_expected();
		row_t         r;
		logic         clr;
		logic         sel;
		logic         phase;
		logic         rise;
		logic [1:0]   cnt;
		port_idx_t    port;
		int           idle;
		mouse_delta_t acc_x;
		mouse_delta_t acc_y;
		mouse_delta_t rep_x;
		mouse_delta_t rep_y;
		clr = 1'b0;
		sel = 1'b0;
		phase = 1'b0;
		cnt = 2'd3;
		port = 3'd0;
		idle = 0;
		acc_x = '0;
		acc_y = '0;
		rep_x = '0;
		rep_y = '0;
		for (int i = 0; i < n_rows; i++) begin
			r = rows[i];
			rise = 1'b0;
			if (!clr) begin
				idle += ROW_CYCLES;
			end
			case (r.op)
				OP_CLEAR: rise = 1'b1;
				OP_CLR: begin
					rise = r.arg[0] & ~clr;
					clr = r.arg[0];
				end
				OP_SEL, OP_PULSE: begin
					if ((r.op == OP_PULSE || r.arg[0]) && !sel && !clr && r.turbo) begin
						port = port + 3'd1;
					end
					sel = (r.op == OP_SEL) & r.arg[0];
				end
				OP_STROBE: begin
					acc_x = -r.mx;
					acc_y = r.my;
				end
				OP_IDLE: idle += int'(r.arg);
				default: ;
			endcase
			if (idle > TIMEOUT_CYCLES) begin
				cnt = 2'd3;
			end
			if (rise) begin
				port = 3'd0;
				phase = r.six & ~phase;
				// Last nibble read, so report the pending movement
				if (cnt == 2'd3) begin
					rep_x = acc_x;
					rep_y = acc_y;
					acc_x = '0;
					acc_y = '0;
				end
				cnt = cnt + 2'd1;
				idle = 0;
			end
			if (clr) begin
				port = 3'd0;
				idle = 0;
			end
			r.exp_port = port;
			r.exp_nib = clr ? 4'h0 : nibble_ref(r, port, phase, sel, cnt, rep_x, rep_y);
			rows[i] = r;
		end
	endtask

	// ========================================
	// Driving and checking
	// ========================================

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk_sys);
		#1;
		joy_a = r.joy[0];
		joy_b = r.joy[1];
		joy_2 = r.joy[2];
		joy_3 = r.joy[3];
		joy_4 = r.joy[4];
		swap_pads = r.swap;
		turbo_tap = r.turbo;
		six_button = r.six;
		mouse_en = r.men;
		mouse_x = r.mx;
		mouse_y = r.my;
		mouse_left = r.mbtn[1];
		mouse_right = r.mbtn[0];
		case (r.op)
			OP_CLEAR: begin
				pad_clr = 1'b1;
				wait_cycles(2);
				pad_clr = 1'b0;
			end
			OP_CLR: pad_clr = r.arg[0];
			OP_SEL: pad_sel = r.arg[0];
			OP_PULSE: begin
				pad_sel = 1'b1;
				wait_cycles(2);
				pad_sel = 1'b0;
			end
			OP_STROBE: begin
				mouse_strobe = 1'b1;
				wait_cycles(1);
				mouse_strobe = 1'b0;
			end
			OP_IDLE: wait_cycles(int'(r.arg));
			default: ;
		endcase
		wait_cycles(3);
	endtask

	task automatic compare_nibble(input int row, input nibble_t expected, input nibble_t actual);
		if (actual !== expected) begin
			nib_errors++;
			$display("[FAIL] %0t ns: row %0d nibble expected %h, got %h",
				$time, row, expected, actual);
		end
	endtask

	task automatic verify_port(input int row, input port_idx_t expected, input port_idx_t actual);
		if (actual !== expected) begin
			port_errors++;
			$display("[FAIL] %0t ns: row %0d port expected %0d, got %0d",
				$time, row, expected, actual);
		end
	endtask

	initial begin
		wait (table_ready);
		repeat (n_rows * 80 + 500) @(posedge clk_sys);
		$display("Timeout: the table did not finish within %0d cycles", n_rows * 80 + 500);
		$display("test failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		joy_a = '0;
		joy_b = '0;
		joy_2 = '0;
		joy_3 = '0;
		joy_4 = '0;
		swap_pads = 1'b0;
		turbo_tap = 1'b0;
		six_button = 1'b0;
		mouse_en = 1'b0;
		mouse_x = '0;
		mouse_y = '0;
		mouse_left = 1'b0;
		mouse_right = 1'b0;
		mouse_strobe = 1'b0;
		pad_sel = 1'b0;
		pad_clr = 1'b0;
		build_table();
		compute_expected();
		table_ready = 1'b1;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			apply_row(rows[i]);
			compare_nibble(i, rows[i].exp_nib, pad_nibble);
			verify_port(i, rows[i].exp_port, i_dut.port_idx);
		end
		$display("Rows %0d, nibble errors %0d, port errors %0d",
			n_rows, nib_errors, port_errors);
		if (nib_errors + port_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: hdl/mouse_report.sv
// Mouse movement reporter
// Accumulates host deltas, hands them out as four nibbles between
// clear pulses and resynchronizes after a long idle period

`timescale 1ns/1ns

module mouse_report
	import pce_pad_pkg::*;
#(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         pad_clr,
	input  logic         mouse_strobe,
	input  mouse_delta_t mouse_x,
	input  mouse_delta_t mouse_y,
	output nibble_t      motion_nibble
);

	logic                          clr_prev;
	logic                          clr_rise;
	logic [1:0]                    nib_cnt;
	logic [MOUSE_TIMEOUT_BITS-1:0] idle_cnt;

	// Pending movement, and the pair being reported
	mouse_delta_t acc_x;
	mouse_delta_t acc_y;
	mouse_delta_t rep_x;
	mouse_delta_t rep_y;

	assign clr_rise = pad_clr & ~clr_prev;

	// ========================================
	// Nibble count and idle timeout
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_prev <= 1'b0;
			idle_cnt <= '0;
			nib_cnt  <= 2'd3;
			acc_x    <= '0;
			acc_y    <= '0;
			rep_x    <= '0;
			rep_y    <= '0;
		end else begin
			clr_prev <= pad_clr;

			if (pad_clr) begin
				idle_cnt <= '0;
			end else if (~&idle_cnt) begin
				idle_cnt <= idle_cnt + 1'b1;
			end

			// Console gave up, next burst starts at X high
			if (&idle_cnt) begin
				nib_cnt <= 2'd3;
			end

			if (clr_rise) begin
				nib_cnt <= nib_cnt + 2'd1;
				if (&nib_cnt) begin
					rep_x <= acc_x;
					rep_y <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end

			// Strobe wins over the clear above
			if (mouse_strobe) begin
				acc_x <= -mouse_x;
				acc_y <= mouse_y;
			end
		end
	end

	// ========================================
	// Nibble out
	// ========================================

	always_comb begin
		case (nib_cnt)
			2'd0:    motion_nibble = rep_x[7:4];
			2'd1:    motion_nibble = rep_x[3:0];
			2'd2:    motion_nibble = rep_y[7:4];
			default: motion_nibble = rep_y[3:0];
		endcase
	end

endmodule

// File: hdl/pad_input_top.sv
// Controller port of the console
// Joins the pad word formatter, the multitap port scanner and the
// mouse movement reporter behind the select and clear lines

`timescale 1ns/1ns

module pad_input_top
	import pce_pad_pkg::*;
#(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  logic         clk_sys,
	input  logic         reset,

	// Host joysticks and options
	input  host_joy_t    joy_a,
	input  host_joy_t    joy_b,
	input  host_joy_t    joy_2,
	input  host_joy_t    joy_3,
	input  host_joy_t    joy_4,
	input  logic         swap_pads,
	input  logic         turbo_tap,
	input  logic         six_button,
	input  logic         mouse_en,

	// Host mouse
	input  mouse_delta_t mouse_x,
	input  mouse_delta_t mouse_y,
	input  logic         mouse_left,
	input  logic         mouse_right,
	input  logic         mouse_strobe,

	// Console port
	input  logic         pad_sel,
	input  logic         pad_clr,
	output nibble_t      pad_nibble
);

	port_idx_t port_idx;
	nibble_t   motion_nibble;
	pad_word_t pad_word;

	pad_word_format i_word_format (
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_2         (joy_2),
		.joy_3         (joy_3),
		.joy_4         (joy_4),
		.swap_pads     (swap_pads),
		.mouse_en      (mouse_en),
		.mouse_left    (mouse_left),
		.mouse_right   (mouse_right),
		.motion_nibble (motion_nibble),
		.port_idx      (port_idx),
		.pad_word      (pad_word)
	);

	pad_port_scan i_port_scan (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pad_sel    (pad_sel),
		.pad_clr    (pad_clr),
		.turbo_tap  (turbo_tap),
		.six_button (six_button),
		.pad_word   (pad_word),
		.port_idx   (port_idx),
		.pad_nibble (pad_nibble)
	);

	mouse_report #(
		.MOUSE_TIMEOUT_BITS (MOUSE_TIMEOUT_BITS)
	) i_mouse_report (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pad_clr       (pad_clr),
		.mouse_strobe  (mouse_strobe),
		.mouse_x       (mouse_x),
		.mouse_y       (mouse_y),
		.motion_nibble (motion_nibble)
	);

endmodule

// File: hdl/pad_port_scan.sv
// Port scanner
// Follows the select and clear lines, steps the multitap port, keeps
// the six-button phase and latches the nibble seen by the console

`timescale 1ns/1ns

module pad_port_scan
	import pce_pad_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      pad_sel,
	input  logic      pad_clr,
	input  logic      turbo_tap,
	input  logic      six_button,
	input  pad_word_t pad_word,
	output port_idx_t port_idx,
	output nibble_t   pad_nibble
);

	// ========================================
	// Edge detection
	// ========================================

	logic sel_prev;
	logic clr_prev;
	logic sel_rise;
	logic clr_rise;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_prev <= 1'b0;
			clr_prev <= 1'b0;
		end else begin
			sel_prev <= pad_sel;
			clr_prev <= pad_clr;
		end
	end

	assign sel_rise = pad_sel & ~sel_prev;
	assign clr_rise = pad_clr & ~clr_prev;

	// ========================================
	// Port, phase and output nibble
	// ========================================

	// High phase exposes buttons III-VI on the six-button pad
	logic       phase;
	logic [1:0] nibble_sel;

	assign nibble_sel = {phase, pad_sel};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_idx   <= '0;
			phase      <= 1'b0;
			pad_nibble <= '0;
		end else begin
			if (pad_clr) begin
				port_idx   <= '0;
				pad_nibble <= '0;
				if (clr_rise) begin
					phase <= six_button & ~phase;
				end
			end else begin
				pad_nibble <= pad_word[{nibble_sel, 2'b00} +: 4];
				// Multitap step, wraps 7 -> 0
				if (sel_rise && turbo_tap) begin
					port_idx <= port_idx + 3'd1;
				end
			end
		end
	end

endmodule

// File: hdl/pad_word_format.sv
// Pad word formatter
// Builds the active-low word of the selected port from the host words,
// with pad swap and the mouse byte on port 0

`timescale 1ns/1ns

module pad_word_format
	import pce_pad_pkg::*;
(
	input  host_joy_t joy_a,
	input  host_joy_t joy_b,
	input  host_joy_t joy_2,
	input  host_joy_t joy_3,
	input  host_joy_t joy_4,
	input  logic      swap_pads,
	input  logic      mouse_en,
	input  logic      mouse_left,
	input  logic      mouse_right,
	input  nibble_t   motion_nibble,
	input  port_idx_t port_idx,
	output pad_word_t pad_word
);

	// Console order: III-VI | left down right up | I II select run
	function automatic pad_word_t format_word(input host_joy_t j);
		return ~{4'hF, j[11:8], j[1], j[2], j[0], j[3], j[7:4]};
	endfunction

	host_joy_t  port_joy [PAD_COUNT];
	logic [7:0] mouse_byte;

	// Pad swap only touches the first two ports
	assign port_joy[0] = swap_pads ? joy_b : joy_a;
	assign port_joy[1] = swap_pads ? joy_a : joy_b;
	assign port_joy[2] = joy_2;
	assign port_joy[3] = joy_3;
	assign port_joy[4] = joy_4;

	// Run and select still come from pad 0
	assign mouse_byte = {motion_nibble,
		~port_joy[0][7], ~port_joy[0][6], ~mouse_left, ~mouse_right};

	always_comb begin
		if (port_idx >= PAD_COUNT) begin
			pad_word = EMPTY_PORT_WORD;
		end else if (port_idx == 3'd0 && mouse_en) begin
			pad_word = {mouse_byte, mouse_byte};
		end else begin
			pad_word = format_word(port_joy[port_idx]);
		end
	end

endmodule

// File: hdl/pce_pad_pkg.sv
// Controller port shared definitions
// Widths, port count and constant pad words used by the pad input blocks

package pce_pad_pkg;

	// ========================================
	// Host side
	// ========================================

	// Host joystick word, one bit per control, 1 = pressed
	//   [3:0]  right, left, down, up
	//   [7:4]  I, II, select, run
	//   [11:8] III to VI
	typedef logic [11:0] host_joy_t;

	// Signed mouse movement, already cut to eight bits
	typedef logic signed [7:0] mouse_delta_t;

	// ========================================
	// Console side
	// ========================================

	// Active-low word for one port, four nibbles
	typedef logic [15:0] pad_word_t;

	// Value on the port lines
	typedef logic [3:0] nibble_t;

	// Multitap port number, 5 to 7 are unused
	typedef logic [2:0] port_idx_t;

	// Ports with a real device behind them
	localparam port_idx_t PAD_COUNT = 3'd5;

	// Nothing connected
	localparam pad_word_t EMPTY_PORT_WORD = 16'h0FFF;

endpackage

// File: list.f
hdl/pce_pad_pkg.sv
hdl/pad_word_format.sv
hdl/pad_port_scan.sv
hdl/mouse_report.sv
hdl/pad_input_top.sv
dv/pad_input_assert.sv
dv/tb_pad_input.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the controller port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pad_input -f list.f -o tb_pad_input_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pad_input_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	echo "FAIL, see $LOG"
	exit 1
fi

echo "PASS"
exit 0
